// ==== sim.f ====
rtl/chip_pkg.sv
rtl/dps_pinmux.sv
rtl/ram_main.sv
rtl/snoop_cfg_regs.sv
rtl/sw_status_snoop.sv
rtl/chip_top.sv
testbench/tb_chip.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the debug harness testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_chip -f sim.f -o tb_chip
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_chip)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q -F '*** PASSED ***'; then
  exit 0
fi

echo "Simulation did not report a pass"
exit 1

// ==== testbench/tb_chip.sv ====
// Testbench for the debug harness top level
// Step table with a reference RAM model, typed compare tasks and a cycle limit
`timescale 1ns/1ps
`default_nettype none

module tb_chip;

  localparam int                         RamWords      = 1024;
  localparam logic [chip_pkg::RamAw-1:0] LogAddrRst    = 10'h3f0;
  localparam logic [chip_pkg::RamAw-1:0] StatusAddrRst = 10'h3f8;

  typedef enum logic [2:0] {
    StepRead,
    StepWrite,
    StepCfg,
    StepPins,
    StepReset
  } step_kind_e;

  // One table entry, unused fields stay zero
  typedef struct packed {
    step_kind_e                 kind;
    logic [chip_pkg::RamAw-1:0] addr;
    logic [31:0]                data;
    logic [1:0]                 sel;
    chip_pkg::dps_in_t          dps;
    logic                       tdo;
    logic                       miso;
    logic                       exp_status;
    logic                       exp_log;
  } step_t;

  logic                 clk_i;
  logic                 reset_i;
  chip_pkg::ram_req_t   host_req_i;
  logic [31:0]          rdata_o;
  logic                 cfg_we_i;
  logic [1:0]           cfg_sel_i;
  logic [31:0]          cfg_wdata_i;
  logic                 status_valid_o;
  chip_pkg::sw_status_e status_o;
  logic                 log_valid_o;
  logic [31:0]          log_data_o;
  chip_pkg::dps_in_t    dps_i;
  logic                 jtag_tdo_i;
  logic                 spi_miso_i;
  logic                 dps2_o;
  chip_pkg::jtag_pins_t jtag_o;
  chip_pkg::spi_pins_t  spi_o;
  logic                 srst_n_o;
  logic                 bootstrap_o;

  step_t       steps[$];
  logic [31:0] ram_model [RamWords];
  logic        strap_mode;
  int          errors;
  int          checks;
  int          cycles;
  int          cycle_limit;

  chip_top #(
    .RamWords      (RamWords),
    .LogAddrRst    (LogAddrRst),
    .StatusAddrRst (StatusAddrRst)
  ) DUT (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .host_req_i     (host_req_i),
    .rdata_o        (rdata_o),
    .cfg_we_i       (cfg_we_i),
    .cfg_sel_i      (cfg_sel_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .status_valid_o (status_valid_o),
    .status_o       (status_o),
    .log_valid_o    (log_valid_o),
    .log_data_o     (log_data_o),
    .dps_i          (dps_i),
    .jtag_tdo_i     (jtag_tdo_i),
    .spi_miso_i     (spi_miso_i),
    .dps2_o         (dps2_o),
    .jtag_o         (jtag_o),
    .spi_o          (spi_o),
    .srst_n_o       (srst_n_o),
    .bootstrap_o    (bootstrap_o)
  );

  always #2 clk_i = ~clk_i;

  // Run limit, armed once the table length is known
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic check_word(input logic [31:0] act, input logic [31:0] exp, input string what);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at time %0t: %s is %h, expected %h", $time, what, act, exp);
    end
  endtask

  task automatic check_status(input chip_pkg::sw_status_e act, input chip_pkg::sw_status_e exp,
                              input string what);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at time %0t: %s is %h, expected %h", $time, what, act, exp);
    end
  endtask

  task automatic check_jtag(input chip_pkg::jtag_pins_t act, input chip_pkg::jtag_pins_t exp,
                            input string what);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at time %0t: %s is %b, expected %b", $time, what, act, exp);
    end
  endtask

  task automatic check_spi(input chip_pkg::spi_pins_t act, input chip_pkg::spi_pins_t exp,
                           input string what);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at time %0t: %s is %b, expected %b", $time, what, act, exp);
    end
  endtask

  // Expected pad routing for the mode fixed at reset
  function automatic chip_pkg::jtag_pins_t expect_jtag(logic jtag_mode, chip_pkg::dps_in_t d);
    chip_pkg::jtag_pins_t j;
    j = '0;
    if (jtag_mode) begin
      j.tck    = d.dps0;
      j.tdi    = d.dps1;
      j.tms    = d.dps3;
      j.trst_n = d.dps4;
    end
    return j;
  endfunction

  function automatic chip_pkg::spi_pins_t expect_spi(logic jtag_mode, chip_pkg::dps_in_t d);
    chip_pkg::spi_pins_t s;
    s     = '0;
    s.csb = 1'b1;
    if (!jtag_mode) begin
      s.sck  = d.dps0;
      s.mosi = d.dps1;
      s.csb  = d.dps3;
    end
    return s;
  endfunction

  function automatic void add_access(step_kind_e kind, logic [chip_pkg::RamAw-1:0] addr,
                                     logic [31:0] data, logic exp_status, logic exp_log);
    step_t s;
    s            = '0;
    s.kind       = kind;
    s.addr       = addr;
    s.data       = data;
    s.exp_status = exp_status;
    s.exp_log    = exp_log;
    steps.push_back(s);
  endfunction

  function automatic void add_cfg(logic [1:0] sel, logic [31:0] data);
    step_t s;
    s      = '0;
    s.kind = StepCfg;
    s.sel  = sel;
    s.data = data;
    steps.push_back(s);
  endfunction

  function automatic void add_pins(chip_pkg::dps_in_t dps, logic tdo, logic miso, logic reset);
    step_t s;
    s      = '0;
    s.kind = reset ? StepReset : StepPins;
    s.dps  = dps;
    s.tdo  = tdo;
    s.miso = miso;
    steps.push_back(s);
  endfunction

  function automatic void build_table();
    logic [chip_pkg::RamAw-1:0] addrs [8];
    logic [15:0]                codes [5];
    chip_pkg::dps_in_t          pads;
    codes[0] = chip_pkg::StatusInBoot;
    codes[1] = chip_pkg::StatusInTest;
    codes[2] = chip_pkg::StatusPassed;
    codes[3] = chip_pkg::StatusFailed;
    codes[4] = 16'h5a3c;
    pads      = '0;
    pads.dps6 = 1'b1;
    add_pins(pads, 1'b0, 1'b0, 1'b1);
    // Random data at low addresses, clear of every watched address
    for (int i = 0; i < 8; i++) begin
      addrs[i] = 10'($urandom_range(511, 0));
      add_access(StepWrite, addrs[i], $urandom, 1'b0, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      add_access(StepRead, addrs[7 - i], 32'h0, 1'b0, 1'b0);
    end
    for (int i = 0; i < 5; i++) begin
      add_access(StepWrite, StatusAddrRst, {16'($urandom), codes[i]}, 1'b1, 1'b0);
    end
    add_access(StepWrite, LogAddrRst, $urandom, 1'b0, 1'b1);
    add_access(StepWrite, 10'h3f4, $urandom, 1'b0, 1'b0);
    add_access(StepRead, StatusAddrRst, 32'h0, 1'b0, 1'b0);
    // Move both watched addresses
    add_cfg(2'd0, 32'h300);
    add_cfg(2'd1, 32'h308);
    add_access(StepWrite, LogAddrRst, $urandom, 1'b0, 1'b0);
    add_access(StepWrite, StatusAddrRst, $urandom, 1'b0, 1'b0);
    add_access(StepWrite, 10'h300, $urandom, 1'b0, 1'b1);
    add_access(StepWrite, 10'h308, $urandom, 1'b1, 1'b0);
    // Reserved select leaves the status address alone
    add_cfg(2'd3, 32'h100);
    add_access(StepWrite, 10'h308, $urandom, 1'b1, 1'b0);
    // Same address for both events
    add_cfg(2'd0, 32'h308);
    add_access(StepWrite, 10'h308, $urandom, 1'b1, 1'b1);
    add_cfg(2'd2, 32'h0);
    add_access(StepWrite, 10'h308, $urandom, 1'b0, 1'b0);
    add_access(StepWrite, 10'h300, $urandom, 1'b0, 1'b0);
    // JTAG mode, dps6 toggles after reset
    for (int i = 0; i < 6; i++) begin
      pads      = chip_pkg::dps_in_t'(7'($urandom));
      pads.dps6 = i[0];
      add_pins(pads, 1'($urandom), 1'($urandom), 1'b0);
    end
    pads = '0;
    add_pins(pads, 1'b0, 1'b0, 1'b1);
    for (int i = 0; i < 6; i++) begin
      pads = chip_pkg::dps_in_t'(7'($urandom));
      add_pins(pads, 1'($urandom), 1'($urandom), 1'b0);
    end
    // Reset restores enable and the status address
    add_access(StepWrite, StatusAddrRst, {16'h0, codes[2]}, 1'b1, 1'b0);
  endfunction

  task automatic apply_step(input step_t s);
    case (s.kind)
      StepReset: begin
        reset_i = 1'b1;
        dps_i   = s.dps;
        repeat (3) @(posedge clk_i);
        #1;
        reset_i    = 1'b0;
        strap_mode = s.dps.dps6;
        check_word(rdata_o, 32'h0, "rdata_o after reset");
        check_word(32'(status_valid_o), 32'h0, "status_valid_o after reset");
        check_word(32'(log_valid_o), 32'h0, "log_valid_o after reset");
      end
      StepPins: begin
        dps_i      = s.dps;
        jtag_tdo_i = s.tdo;
        spi_miso_i = s.miso;
        #1;
        check_jtag(jtag_o, expect_jtag(strap_mode, s.dps), "jtag_o");
        check_spi(spi_o, expect_spi(strap_mode, s.dps), "spi_o");
        check_word(32'(dps2_o), 32'(strap_mode ? s.tdo : s.miso), "dps2_o");
        check_word(32'(srst_n_o), 32'(s.dps.dps5), "srst_n_o");
        check_word(32'(bootstrap_o), 32'(s.dps.dps7), "bootstrap_o");
        @(posedge clk_i);
        #1;
      end
      default: begin
        host_req_i.req   = (s.kind == StepRead) || (s.kind == StepWrite);
        host_req_i.write = (s.kind == StepWrite);
        host_req_i.addr  = s.addr;
        host_req_i.wdata = s.data;
        cfg_we_i         = (s.kind == StepCfg);
        cfg_sel_i        = s.sel;
        cfg_wdata_i      = s.data;
        @(posedge clk_i);
        #1;
        host_req_i = '0;
        cfg_we_i   = 1'b0;
        if (s.kind == StepRead) begin
          check_word(rdata_o, ram_model[s.addr], "rdata_o");
        end
        if (s.kind == StepWrite) begin
          ram_model[s.addr] = s.data;
        end
        check_word(32'(status_valid_o), 32'(s.exp_status), "status_valid_o");
        check_word(32'(log_valid_o), 32'(s.exp_log), "log_valid_o");
        if (s.exp_status) begin
          check_status(status_o, chip_pkg::sw_status_e'(s.data[15:0]), "status_o");
        end
        if (s.exp_log) begin
          check_word(log_data_o, s.data, "log_data_o");
        end
        // Pulses last a single cycle
        @(posedge clk_i);
        #1;
        check_word(32'(status_valid_o), 32'h0, "status_valid_o second cycle");
        check_word(32'(log_valid_o), 32'h0, "log_valid_o second cycle");
      end
    endcase
  endtask

  initial begin
    void'($urandom(66));
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    host_req_i  = '0;
    cfg_we_i    = 1'b0;
    cfg_sel_i   = 2'd0;
    cfg_wdata_i = 32'h0;
    dps_i       = '0;
    jtag_tdo_i  = 1'b0;
    spi_miso_i  = 1'b0;
    strap_mode  = 1'b0;
    errors      = 0;
    checks      = 0;
    cycles      = 0;
    cycle_limit = 0;
    build_table();
    cycle_limit = steps.size() * 4 + 50;
    foreach (steps[i]) begin
      apply_step(steps[i]);
    end
    $display("tb_chip: %0d steps, %0d checks, %0d errors", steps.size(), checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/chip_top.sv ====
// Debug harness top level
// Pin multiplexer, main RAM, snoop configuration registers and write snoop
`timescale 1ns/1ps
`default_nettype none

module chip_top #(
  parameter int                         RamWords      = 1024,
  parameter logic [chip_pkg::RamAw-1:0] LogAddrRst    = 10'h3f0,
  parameter logic [chip_pkg::RamAw-1:0] StatusAddrRst = 10'h3f8
) (
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,

  // Host RAM port
  input  wire chip_pkg::ram_req_t     host_req_i,
  output logic [31:0]                 rdata_o,

  // Snoop configuration strobe
  input  wire logic                   cfg_we_i,
  input  wire logic [1:0]             cfg_sel_i,
  input  wire logic [31:0]            cfg_wdata_i,

  // Snoop events
  output logic                        status_valid_o,
  output chip_pkg::sw_status_e        status_o,
  output logic                        log_valid_o,
  output logic [31:0]                 log_data_o,

  // Debug pads
  input  wire chip_pkg::dps_in_t      dps_i,
  input  wire logic                   jtag_tdo_i,
  input  wire logic                   spi_miso_i,
  output logic                        dps2_o,
  output chip_pkg::jtag_pins_t        jtag_o,
  output chip_pkg::spi_pins_t         spi_o,
  output logic                        srst_n_o,
  output logic                        bootstrap_o
);

  chip_pkg::snoop_cfg_t snoop_cfg;

  dps_pinmux u_dps_pinmux (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .dps_i       (dps_i),
    .jtag_tdo_i  (jtag_tdo_i),
    .spi_miso_i  (spi_miso_i),
    .dps2_o      (dps2_o),
    .jtag_o      (jtag_o),
    .spi_o       (spi_o),
    .srst_n_o    (srst_n_o),
    .bootstrap_o (bootstrap_o)
  );

  ram_main #(
    .RamWords (RamWords)
  ) u_ram_main (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (host_req_i),
    .rdata_o (rdata_o)
  );

  snoop_cfg_regs #(
    .LogAddrRst    (LogAddrRst),
    .StatusAddrRst (StatusAddrRst)
  ) u_snoop_cfg_regs (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_sel_i   (cfg_sel_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_o       (snoop_cfg)
  );

  // Snoop sees the same request the RAM does
  sw_status_snoop u_sw_status_snoop (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_i          (host_req_i),
    .cfg_i          (snoop_cfg),
    .status_valid_o (status_valid_o),
    .status_o       (status_o),
    .log_valid_o    (log_valid_o),
    .log_data_o     (log_data_o)
  );

endmodule

`default_nettype wire

// ==== rtl/sw_status_snoop.sv ====
// Software status and log snoop
// Watches host writes to the main RAM and raises one-cycle event pulses
`timescale 1ns/1ps
`default_nettype none

module sw_status_snoop (
  input  wire logic                 clk_i,
  input  wire logic                 reset_i,
  input  wire chip_pkg::ram_req_t   req_i,
  input  wire chip_pkg::snoop_cfg_t cfg_i,
  output logic                      status_valid_o,
  output chip_pkg::sw_status_e      status_o,
  output logic                      log_valid_o,
  output logic [31:0]               log_data_o
);

  logic                 wr_seen;
  logic                 status_hit;
  logic                 log_hit;

  logic                 status_valid_q;
  chip_pkg::sw_status_e status_q;
  logic                 log_valid_q;
  logic [31:0]          log_data_q;

  // Qualified write to the RAM port
  assign wr_seen = req_i.req & req_i.write & cfg_i.enable;

  // Both hits may fire together when the two addresses match
  assign status_hit = wr_seen && (req_i.addr == cfg_i.status_addr);
  assign log_hit    = wr_seen && (req_i.addr == cfg_i.log_addr);

  // Event pulses
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      status_valid_q <= 1'b0;
      log_valid_q    <= 1'b0;
    end else begin
      status_valid_q <= status_hit;
      log_valid_q    <= log_hit;
    end
  end

  // Event data, only the low half-word carries a status code
  always_ff @(posedge clk_i) begin
    if (status_hit) begin
      status_q <= chip_pkg::sw_status_e'(req_i.wdata[15:0]);
    end
    if (log_hit) begin
      log_data_q <= req_i.wdata;
    end
  end

  assign status_valid_o = status_valid_q;
  assign status_o       = status_q;
  assign log_valid_o    = log_valid_q;
  assign log_data_o     = log_data_q;

  // Disabled snoop stays quiet on the following cycle
  no_event_when_disabled_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !cfg_i.enable |=> !(status_valid_o || log_valid_o)
  ) else $error("snoop event while disabled");

endmodule

`default_nettype wire

// ==== rtl/snoop_cfg_regs.sv ====
// Snoop configuration registers
// Watched log address, watched status address and the snoop enable
`timescale 1ns/1ps
`default_nettype none

module snoop_cfg_regs #(
  parameter logic [chip_pkg::RamAw-1:0] LogAddrRst    = '0,
  parameter logic [chip_pkg::RamAw-1:0] StatusAddrRst = '0
) (
  input  wire logic                 clk_i,
  input  wire logic                 reset_i,
  input  wire logic                 cfg_we_i,
  input  wire logic [1:0]           cfg_sel_i,
  input  wire logic [31:0]          cfg_wdata_i,
  output chip_pkg::snoop_cfg_t      cfg_o
);

  // Field selects
  localparam logic [1:0] SelLogAddr    = 2'd0;
  localparam logic [1:0] SelStatusAddr = 2'd1;
  localparam logic [1:0] SelEnable     = 2'd2;

  chip_pkg::snoop_cfg_t cfg_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_q.log_addr    <= LogAddrRst;
      cfg_q.status_addr <= StatusAddrRst;
      cfg_q.enable      <= 1'b1;
    end else if (cfg_we_i) begin
      case (cfg_sel_i)
        SelLogAddr: begin
          cfg_q.log_addr <= cfg_wdata_i[chip_pkg::RamAw-1:0];
        end
        SelStatusAddr: begin
          cfg_q.status_addr <= cfg_wdata_i[chip_pkg::RamAw-1:0];
        end
        SelEnable: begin
          cfg_q.enable <= cfg_wdata_i[0];
        end
        // Select 3 is reserved, write dropped
        default: ;
      endcase
    end
  end

  assign cfg_o = cfg_q;

endmodule

`default_nettype wire

// ==== rtl/ram_main.sv ====
// Main RAM
// Single-port 32-bit word memory, read data registered one cycle after request
`timescale 1ns/1ps
`default_nettype none

module ram_main #(
  parameter int RamWords = 1024
) (
  input  wire logic               clk_i,
  input  wire logic               reset_i,
  input  wire chip_pkg::ram_req_t req_i,
  output logic [31:0]             rdata_o
);

  logic [31:0] mem [RamWords];
  logic [31:0] rdata_q;
  logic        wr_en;
  logic        rd_en;

  assign wr_en = req_i.req & req_i.write;
  assign rd_en = req_i.req & ~req_i.write;

  // Storage array
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[req_i.addr] <= req_i.wdata;
    end
  end

  // Read port, holds last read between requests
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rdata_q <= '0;
    end else if (rd_en) begin
      rdata_q <= mem[req_i.addr];
    end
  end

  assign rdata_o = rdata_q;

  // Host must stay inside the populated depth
  addr_in_range_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    req_i.req |-> (int'(req_i.addr) < RamWords)
  ) else $error("RAM address %0d out of range", req_i.addr);

endmodule

`default_nettype wire

// ==== rtl/dps_pinmux.sv ====
// Debug pin multiplexer
// Strap sampling during reset and JTAG or SPI routing of the shared pads
`timescale 1ns/1ps
`default_nettype none

module dps_pinmux (
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  input  wire chip_pkg::dps_in_t      dps_i,
  input  wire logic                   jtag_tdo_i,
  input  wire logic                   spi_miso_i,
  output logic                        dps2_o,
  output chip_pkg::jtag_pins_t        jtag_o,
  output chip_pkg::spi_pins_t         spi_o,
  output logic                        srst_n_o,
  output logic                        bootstrap_o
);

  // Strap follows dps6 while reset is high and freezes afterwards
  logic strap_q;
  logic jtag_mode;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      strap_q <= dps_i.dps6;
    end
  end

  // 1 selects JTAG, 0 selects the SPI device
  assign jtag_mode = strap_q;

  always_comb begin
    // Idle levels for whichever side is not selected
    jtag_o        = '0;
    spi_o         = '0;
    spi_o.csb     = 1'b1;

    if (jtag_mode) begin
      jtag_o.tck    = dps_i.dps0;
      jtag_o.tdi    = dps_i.dps1;
      jtag_o.tms    = dps_i.dps3;
      jtag_o.trst_n = dps_i.dps4;
    end else begin
      spi_o.sck     = dps_i.dps0;
      spi_o.mosi    = dps_i.dps1;
      spi_o.csb     = dps_i.dps3;
    end
  end

  // Single return pin
  assign dps2_o = jtag_mode ? jtag_tdo_i : spi_miso_i;

  // Pads that are not shared pass straight through
  assign srst_n_o    = dps_i.dps5;
  assign bootstrap_o = dps_i.dps7;

  // Mode must not move once reset has been released
  strap_frozen_a: assert property (
    @(posedge clk_i) !reset_i |=> $stable(strap_q)
  ) else $error("strap changed outside reset");

endmodule

`default_nettype wire

// ==== rtl/chip_pkg.sv ====
// Shared types for the debug harness
// RAM request, debug pin groups, snoop configuration and test status codes
`default_nettype none

package chip_pkg;

  // Word address width of the main RAM
  localparam int RamAw = 10;

  // One host access to the main RAM
  typedef struct packed {
    logic             req;
    logic             write;
    logic [RamAw-1:0] addr;
    logic [31:0]      wdata;
  } ram_req_t;

  // JTAG signals toward the chip
  typedef struct packed {
    logic tck;
    logic tms;
    logic trst_n;
    logic tdi;
  } jtag_pins_t;

  // SPI device signals toward the chip
  typedef struct packed {
    logic sck;
    logic csb;
    logic mosi;
  } spi_pins_t;

  // Input debug pads, dps2 is the only output and is not part of this group
  typedef struct packed {
    logic dps0;
    logic dps1;
    logic dps3;
    logic dps4;
    logic dps5;
    logic dps6;
    logic dps7;
  } dps_in_t;

  // Codes written by software to the test status location
  typedef enum logic [15:0] {
    StatusInBoot = 16'hb090,
    StatusInTest = 16'h4354,
    StatusPassed = 16'h900d,
    StatusFailed = 16'hbaad
  } sw_status_e;

  // Watched addresses and enable for the write snoop
  typedef struct packed {
    logic [RamAw-1:0] log_addr;
    logic [RamAw-1:0] status_addr;
    logic             enable;
  } snoop_cfg_t;

endpackage

`default_nettype wire
